//--- compile.f
logic/cpuPkg.sv
logic/exCtrlIf.sv
logic/instrDecoder.sv
logic/accumulatorBank.sv
logic/executeStage.sv
logic/dataMemory.sv
logic/pipeControl.sv
logic/cpuCore.sv
bench/cpuCoreChecker.sv
bench/cpuCoreTb.sv

//--- bench/cpuCoreTb.sv
module cpuCoreTb;
	timeunit 1ns;
	timeprecision 1ps;
	import cpuPkg::*;

	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rstN;
	logic instrValid;
	logic [15:0] instr;
	logic storeCredit;
	logic instrCredit;
	logic storeValid;
	logic [9:0] storeAddr;
	logic [7:0] storeData;
	logic [7:0] accA;
	logic [7:0] accB;
	logic carry;

	// fetch agent and store consumer state
	int agentCredits;
	int owedCredits;
	logic holdCredits;
	logic creditsOpen;
	logic [17:0] reportQ [$];
	logic [17:0] expQ [$];

	// reference model of the core
	logic [7:0] refA;
	logic [7:0] refB;
	logic refCarry;
	logic [7:0] refMem [1024];

	// first 16 are the ALU forms, then the two shifts
	logic [5:0] arithOps [18];
	int errorCount;
	int timeoutCount;

	cpuCore i_dut (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.storeCredit(storeCredit),
		.instrCredit(instrCredit),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.accA(accA),
		.accB(accB),
		.carry(carry)
	);

	always #5 clk = ~clk;

	function automatic logic [15:0] immWord(input logic [5:0] op, input logic [7:0] k);
		return {op, 2'b00, k};
	endfunction

	function automatic logic [15:0] addrWord(input logic [5:0] op, input logic [9:0] a);
		return {op, a};
	endfunction

	// two-operand forms, x op y
	function automatic logic [7:0] refAlu(
		input logic [5:0] op,
		input logic [7:0] x,
		input logic [7:0] y
	);
		logic [8:0] sum;
		sum = {1'b0, x} + {1'b0, y};
		if (op inside {ADDA, ADDB, ADDCA, ADDCB}) begin
			refCarry = sum[8];
			return sum[7:0];
		end
		if (op inside {SUBA, SUBB, SUBCA, SUBCB}) begin
			// borrow whenever the subtrahend is larger
			refCarry = (y > x);
			return x - y;
		end
		if (op inside {ANDA, ANDB, ANDCA, ANDCB}) begin
			return x & y;
		end
		return x | y;
	endfunction

	// applied in issue order, so it follows program order
	function automatic void applyModel(input logic [15:0] word);
		logic [5:0] op;
		logic [7:0] k;
		logic [9:0] a;
		op = word[15:10];
		k = word[7:0];
		a = word[9:0];
		case (op)
			LDA: refA = refMem[a];
			LDB: refB = refMem[a];
			LDCA: refA = k;
			LDCB: refB = k;
			STA: begin
				refMem[a] = refA;
				expQ.push_back({a, refA});
			end
			STB: begin
				refMem[a] = refB;
				expQ.push_back({a, refB});
			end
			ADDA, SUBA, ANDA, ORA: refA = refAlu(op, refA, refB);
			ADDB, SUBB, ANDB, ORB: refB = refAlu(op, refA, refB);
			// constant replaces the other accumulator
			ADDCA, SUBCA, ANDCA, ORCA: refA = refAlu(op, refA, k);
			ADDCB, SUBCB, ANDCB, ORCB: refB = refAlu(op, k, refB);
			ASLA: begin
				refCarry = refA[7];
				refA = refA << 1;
			end
			ASRA: begin
				refCarry = refA[0];
				refA = $signed(refA) >>> 1;
			end
			default: ;
		endcase
	endfunction

	task automatic finishRun();
		int assertFails;
		assertFails = i_dut.creditChk.assertFails;
		$display("check errors: %0d, assertion failures: %0d, timeouts: %0d",
			errorCount, assertFails, timeoutCount);
		if (errorCount == 0 && assertFails == 0 && timeoutCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	task automatic reportTimeout(input string why);
		timeoutCount++;
		$display("timeout: %s", why);
	endtask

	task automatic reportMismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		errorCount++;
		$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
	endtask

	// fetch agent, one instruction per credit
	task automatic sendInstr(input logic [15:0] word);
		int waited;
		waited = 0;
		while (agentCredits == 0 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (agentCredits == 0) begin
			reportTimeout("fetch agent got no instruction credit back");
		end else begin
			applyModel(word);
			agentCredits--;
			instrValid = 1'b1;
			instr = word;
			@(posedge clk);
			#1;
			instrValid = 1'b0;
		end
	endtask

	// all credits home means the last instruction has executed
	task automatic drainCore(input string tag);
		int waited;
		waited = 0;
		while ((agentCredits != INSTR_CREDITS || owedCredits != 0) && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (agentCredits != INSTR_CREDITS || owedCredits != 0) begin
			reportTimeout({tag, ": core did not drain"});
		end
	endtask

	task automatic checkState(input string tag);
		if (accA !== refA) reportMismatch({tag, " accA"}, accA, refA);
		if (accB !== refB) reportMismatch({tag, " accB"}, accB, refB);
		if (carry !== refCarry) reportMismatch({tag, " carry"}, carry, refCarry);
	endtask

	task automatic checkReports(input string tag);
		if (reportQ.size() != expQ.size()) begin
			reportMismatch({tag, " report count"}, reportQ.size(), expQ.size());
		end
		for (int i = 0; i < expQ.size() && i < reportQ.size(); i++) begin
			if (reportQ[i] !== expQ[i]) begin
				reportMismatch($sformatf("%s report %0d addr,data", tag, i), reportQ[i], expQ[i]);
			end
		end
		reportQ.delete();
		expQ.delete();
	endtask

	task automatic resetAndConstants();
		if (accA !== 8'h00) reportMismatch("accA after reset", accA, 0);
		if (accB !== 8'h00) reportMismatch("accB after reset", accB, 0);
		if (carry !== 1'b0) reportMismatch("carry after reset", carry, 0);
		sendInstr(immWord(LDCA, 8'($urandom())));
		sendInstr(immWord(LDCB, 8'($urandom())));
		drainCore("constant loads");
		checkState("constant loads");
	endtask

	task automatic aluForms();
		for (int i = 0; i < 16; i++) begin
			sendInstr(immWord(LDCA, 8'($urandom())));
			sendInstr(immWord(LDCB, 8'($urandom())));
			sendInstr(immWord(arithOps[i], 8'($urandom())));
			drainCore("alu");
			checkState($sformatf("alu opcode %0d", arithOps[i]));
		end
	endtask

	task automatic shiftA();
		for (int i = 0; i < 8; i++) begin
			sendInstr(immWord(LDCA, 8'($urandom())));
			sendInstr(immWord(i % 2 ? ASRA : ASLA, 8'h00));
			drainCore("shift");
			checkState(i % 2 ? "asra" : "asla");
		end
	endtask

	task automatic storeThenLoad();
		logic [9:0] addrs [4];
		for (int i = 0; i < 4; i++) begin
			addrs[i] = 10'($urandom());
			sendInstr(immWord(i % 2 ? LDCB : LDCA, 8'($urandom())));
			sendInstr(addrWord(i % 2 ? STB : STA, addrs[i]));
		end
		drainCore("stores");
		checkReports("stores");
		// read back crosswise into the other accumulator
		for (int i = 0; i < 4; i++) begin
			sendInstr(addrWord(i % 2 ? LDA : LDB, addrs[i]));
			drainCore("loads");
			checkState($sformatf("load %0d", i));
		end
	endtask

	task automatic storeBackPressure();
		logic [7:0] heldA;
		sendInstr(immWord(LDCA, 8'($urandom())));
		sendInstr(immWord(LDCB, 8'($urandom())));
		drainCore("back-pressure setup");
		holdCredits = 1'b1;
		// one store more than the core has credits for
		for (int i = 0; i <= STORE_CREDITS; i++) begin
			sendInstr(addrWord(i % 2 ? STB : STA, 10'($urandom())));
		end
		heldA = refA;
		sendInstr(immWord(LDCA, ~refA));
		// watch the stall hold for a while
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			#1;
			if (reportQ.size() > STORE_CREDITS) begin
				reportMismatch("reports during stall", reportQ.size(), STORE_CREDITS);
			end
		end
		if (reportQ.size() != STORE_CREDITS) begin
			reportMismatch("reports before credit return", reportQ.size(), STORE_CREDITS);
		end
		if (accA !== heldA) reportMismatch("accA during stall", accA, heldA);
		if (agentCredits != 0) reportMismatch("fetch credits during stall", agentCredits, 0);
		holdCredits = 1'b0;
		drainCore("back-pressure release");
		checkReports("back-pressure");
		checkState("back-pressure");
	endtask

	task automatic creditStream();
		for (int i = 0; i < 40; i++) begin
			sendInstr(immWord(arithOps[$urandom_range(17, 0)], 8'($urandom())));
		end
		drainCore("stream");
		checkState("stream");
	endtask

	// monitors sample mid-cycle, outputs settle right after the edge
	always @(negedge clk) begin
		if (rstN && storeValid) begin
			reportQ.push_back({storeAddr, storeData});
			owedCredits++;
		end
		if (rstN && instrCredit) begin
			agentCredits++;
			if (agentCredits > INSTR_CREDITS) begin
				errorCount++;
				$display("FAILED at %0t ns: core returned more instruction credits than spent", $time);
			end
		end
	end

	// store consumer, at most one credit per cycle
	always @(posedge clk) begin
		creditsOpen = !holdCredits;
		#1;
		if (rstN && creditsOpen && owedCredits > 0) begin
			storeCredit = 1'b1;
			owedCredits--;
		end else begin
			storeCredit = 1'b0;
		end
	end

	initial begin
		void'($urandom(32'h7f77_a962));
		clk = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		storeCredit = 1'b0;
		agentCredits = INSTR_CREDITS;
		owedCredits = 0;
		holdCredits = 1'b0;
		errorCount = 0;
		timeoutCount = 0;
		refA = '0;
		refB = '0;
		refCarry = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			refMem[i] = '0;
		end
		arithOps = '{ADDA, ADDB, ADDCA, ADDCB, SUBA, SUBB, SUBCA, SUBCB,
			ANDA, ANDB, ANDCA, ANDCB, ORA, ORB, ORCA, ORCB, ASLA, ASRA};
		repeat (4) @(posedge clk);
		#1;
		rstN = 1'b1;
		resetAndConstants();
		aluForms();
		shiftA();
		storeThenLoad();
		storeBackPressure();
		creditStream();
		finishRun();
	end

endmodule

//--- bench/cpuCoreChecker.sv
module cpuCoreChecker (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic instrCredit,
	input logic storeValid,
	input logic storeCredit
);
	timeunit 1ns;
	timeprecision 1ps;
	import cpuPkg::*;

	// credits the fetch agent holds, and store credits the core holds
	int fetchHeld;
	int storeHeld;
	logic resetSeen = 1'b0;
	// read by the testbench at the end of the run
	int assertFails = 0;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			fetchHeld <= INSTR_CREDITS;
			storeHeld <= STORE_CREDITS;
			resetSeen <= 1'b1;
		end else begin
			fetchHeld <= fetchHeld - int'(instrValid) + int'(instrCredit);
			storeHeld <= storeHeld - int'(storeValid) + int'(storeCredit);
		end
	end

	// push only with a credit in hand
	fetchWithCredit: assert property (@(posedge clk) disable iff (!rstN)
		instrValid |-> fetchHeld > 0)
	else begin
		assertFails++;
		$error("instruction pushed while the fetch agent held no credit");
	end

	// report only with a store credit left
	storeWithCredit: assert property (@(posedge clk) disable iff (!rstN)
		storeValid |-> storeHeld > 0)
	else begin
		assertFails++;
		$error("store reported with the store credit counter at zero");
	end

	// first reset edge has passed, credit output must be quiet
	quietInReset: assert property (@(posedge clk) (!rstN && resetSeen) |-> !instrCredit)
	else begin
		assertFails++;
		$error("instruction credit returned during reset");
	end

endmodule

bind cpuCore cpuCoreChecker creditChk (
	.clk(clk),
	.rstN(rstN),
	.instrValid(instrValid),
	.instrCredit(instrCredit),
	.storeValid(storeValid),
	.storeCredit(storeCredit)
);

//--- logic/cpuCore.sv
module cpuCore (
	input  logic clk,
	input  logic rstN,
	input  logic instrValid,
	input  logic [15:0] instr,
	input  logic storeCredit,
	output logic instrCredit,
	output logic storeValid,
	output logic [9:0] storeAddr,
	output logic [7:0] storeData,
	output logic [7:0] accA,
	output logic [7:0] accB,
	output logic carry
);

	logic issueStall;
	logic headIsStore;
	logic popped;
	logic [2:0] load;
	logic [7:0] loadData;
	logic memWriteEn;
	logic [9:0] memAddr;
	logic [7:0] memWriteData;
	logic [7:0] readData;

	// decode to execute bundle
	exCtrlIf ctrl ();

	instrDecoder instrDec (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.issueStall(issueStall),
		.headIsStore(headIsStore),
		.popped(popped),
		.ctrl(ctrl.decoder)
	);

	pipeControl pipeCtl (
		.clk(clk),
		.rstN(rstN),
		.headIsStore(headIsStore),
		.popped(popped),
		.storeCredit(storeCredit),
		.storeValid(storeValid),
		.issueStall(issueStall),
		.instrCredit(instrCredit)
	);

	executeStage exStage (
		.clk(clk),
		.rstN(rstN),
		.accA(accA),
		.accB(accB),
		.readData(readData),
		.ctrl(ctrl.execute),
		.load(load),
		.loadData(loadData),
		.memWriteEn(memWriteEn),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.storeValid(storeValid),
		.carry(carry)
	);

	accumulatorBank accBank (
		.clk(clk),
		.rstN(rstN),
		.load(load),
		.loadData(loadData),
		.accA(accA),
		.accB(accB)
	);

	dataMemory dataMem (
		.clk(clk),
		.rstN(rstN),
		.addr(memAddr),
		.writeEn(memWriteEn),
		.writeData(memWriteData),
		.readData(readData)
	);

	// store report mirrors the memory write
	assign storeAddr = memAddr;
	assign storeData = memWriteData;

endmodule

//--- logic/pipeControl.sv
module pipeControl (
	input  logic clk,
	input  logic rstN,
	input  logic headIsStore,
	input  logic popped,
	input  logic storeCredit,
	input  logic storeValid,
	output logic issueStall,
	output logic instrCredit
);
	import cpuPkg::*;

	logic [STORE_CNT_W-1:0] storeCount;
	logic [STORE_CNT_W-1:0] storeFree;

	// credits left once the store in execute has spent its own
	assign storeFree = storeCount - STORE_CNT_W'(storeValid);
	// hold a store at the head until it can be reported
	assign issueStall = headIsStore && (storeFree == '0);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			storeCount <= STORE_CNT_W'(STORE_CREDITS);
		end else begin
			storeCount <= storeCount - STORE_CNT_W'(storeValid) + STORE_CNT_W'(storeCredit);
		end
	end

	// one credit back per popped instruction, a cycle later
	always_ff @(posedge clk) begin
		if (!rstN) begin
			instrCredit <= 1'b0;
		end else begin
			instrCredit <= popped;
		end
	end

endmodule

//--- logic/dataMemory.sv
module dataMemory (
	input  logic clk,
	input  logic rstN,
	input  logic [9:0] addr,
	input  logic writeEn,
	input  logic [7:0] writeData,
	output logic [7:0] readData
);
	import cpuPkg::*;

	logic [7:0] mem [MEM_DEPTH];

	// cleared on reset, then filled only by stores
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (writeEn) begin
			mem[addr] <= writeData;
		end
	end

	// asynchronous read
	assign readData = mem[addr];

endmodule

//--- logic/executeStage.sv
module executeStage (
	input  logic clk,
	input  logic rstN,
	input  logic [7:0] accA,
	input  logic [7:0] accB,
	input  logic [7:0] readData,
	exCtrlIf.execute ctrl,
	output logic [2:0] load,
	output logic [7:0] loadData,
	output logic memWriteEn,
	output logic [9:0] memAddr,
	output logic [7:0] memWriteData,
	output logic storeValid,
	output logic carry
);
	import cpuPkg::*;

	logic [7:0] oper1;
	logic [7:0] oper2;
	logic [7:0] aluRes;
	logic [8:0] wideRes;
	logic carryNext;
	logic carryUpd;

	// operand muxes, constant replaces the unused accumulator
	assign oper1 = ctrl.operandSel[0] ? accA : ctrl.constant;
	assign oper2 = ctrl.operandSel[1] ? accB : ctrl.constant;

	always_comb begin
		wideRes = '0;
		aluRes = oper1;
		carryNext = carry;
		carryUpd = 1'b0;
		case (ctrl.aluOp)
			aluAdd: begin
				wideRes = {1'b0, oper1} + {1'b0, oper2};
				aluRes = wideRes[7:0];
				carryNext = wideRes[8];
				carryUpd = 1'b1;
			end
			// bit 8 of the difference is the borrow
			aluSub: begin
				wideRes = {1'b0, oper1} - {1'b0, oper2};
				aluRes = wideRes[7:0];
				carryNext = wideRes[8];
				carryUpd = 1'b1;
			end
			aluAnd: aluRes = oper1 & oper2;
			aluOr: aluRes = oper1 | oper2;
			aluShl: begin
				aluRes = {oper1[6:0], 1'b0};
				carryNext = oper1[7];
				carryUpd = 1'b1;
			end
			// arithmetic shift keeps the sign bit
			aluShr: begin
				aluRes = {oper1[7], oper1[7:1]};
				carryNext = oper1[0];
				carryUpd = 1'b1;
			end
			default: aluRes = oper1;
		endcase
	end

	// result routing back to the accumulators
	assign load = ctrl.valid ? ctrl.accControl : noLoad;
	assign loadData = (ctrl.memControl == memRead) ? readData : aluRes;

	// stores go to memory and out on the store port in the same cycle
	assign memWriteEn = ctrl.valid && (ctrl.memControl == memWrite);
	assign memAddr = ctrl.addr;
	assign memWriteData = ctrl.operandSel[0] ? oper1 : oper2;
	assign storeValid = memWriteEn;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			carry <= 1'b0;
		end else if (ctrl.valid && carryUpd) begin
			carry <= carryNext;
		end
	end

endmodule

//--- logic/accumulatorBank.sv
module accumulatorBank (
	input  logic clk,
	input  logic rstN,
	input  logic [2:0] load,
	input  logic [7:0] loadData,
	output logic [7:0] accA,
	output logic [7:0] accB
);
	import cpuPkg::*;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			accA <= '0;
			accB <= '0;
		end else begin
			// one destination per instruction, the other one holds
			case (load)
				loadA: accA <= loadData;
				loadB: accB <= loadData;
				default: begin
					accA <= accA;
					accB <= accB;
				end
			endcase
		end
	end

endmodule

//--- logic/instrDecoder.sv
module instrDecoder (
	input  logic clk,
	input  logic rstN,
	input  logic instrValid,
	input  cpuPkg::instrWord instr,
	input  logic issueStall,
	output logic headIsStore,
	output logic popped,
	exCtrlIf.decoder ctrl
);
	import cpuPkg::*;

	instrWord buffer [INSTR_CREDITS];
	logic [INSTR_PTR_W-1:0] headPtr;
	logic [INSTR_PTR_W-1:0] tailPtr;
	logic [INSTR_CNT_W-1:0] count;
	instrWord head;
	logic [5:0] opcode;
	aluOpT decAluOp;
	logic [1:0] decOperandSel;
	logic [2:0] decAccControl;
	logic [1:0] decMemControl;

	function automatic logic [INSTR_PTR_W-1:0] nextPtr(input logic [INSTR_PTR_W-1:0] ptr);
		if (ptr == INSTR_PTR_W'(INSTR_CREDITS - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// buffer storage, written by every valid instruction
	always_ff @(posedge clk) begin
		if (instrValid) begin
			buffer[tailPtr] <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			headPtr <= '0;
			tailPtr <= '0;
			count <= '0;
		end else begin
			if (instrValid) begin
				tailPtr <= nextPtr(tailPtr);
			end
			if (popped) begin
				headPtr <= nextPtr(headPtr);
			end
			// push and pop together keep the count
			case ({instrValid, popped})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head = buffer[headPtr];
	assign opcode = head.fmtImm.opcode;
	assign headIsStore = (count != '0) && (opcode == STA || opcode == STB);
	// pop whenever something waits and the store path is free
	assign popped = (count != '0) && !issueStall;

	always_comb begin
		decAluOp = aluPass;
		decOperandSel = selConstants;
		decAccControl = noLoad;
		decMemControl = memNone;
		// operand routing and destination
		case (opcode)
			LDA: begin
				decAccControl = loadA;
				decMemControl = memRead;
			end
			LDB: begin
				decAccControl = loadB;
				decMemControl = memRead;
			end
			LDCA: decAccControl = loadA;
			LDCB: decAccControl = loadB;
			STA: begin
				decOperandSel = selAcumAConstB;
				decMemControl = memWrite;
			end
			STB: begin
				decOperandSel = selConstAAcumB;
				decMemControl = memWrite;
			end
			ADDA, SUBA, ANDA, ORA: begin
				decOperandSel = selAcumAB;
				decAccControl = loadA;
			end
			ADDB, SUBB, ANDB, ORB: begin
				decOperandSel = selAcumAB;
				decAccControl = loadB;
			end
			// constant stands in for B
			ADDCA, SUBCA, ANDCA, ORCA, ASLA, ASRA: begin
				decOperandSel = selAcumAConstB;
				decAccControl = loadA;
			end
			// constant stands in for A
			ADDCB, SUBCB, ANDCB, ORCB: begin
				decOperandSel = selConstAAcumB;
				decAccControl = loadB;
			end
			default: decAccControl = noLoad;
		endcase
		// alu function
		case (opcode)
			ADDA, ADDB, ADDCA, ADDCB: decAluOp = aluAdd;
			SUBA, SUBB, SUBCA, SUBCB: decAluOp = aluSub;
			ANDA, ANDB, ANDCA, ANDCB: decAluOp = aluAnd;
			ORA, ORB, ORCA, ORCB: decAluOp = aluOr;
			ASLA: decAluOp = aluShl;
			ASRA: decAluOp = aluShr;
			default: decAluOp = aluPass;
		endcase
	end

	// registered control bundle
	always_ff @(posedge clk) begin
		if (!rstN) begin
			ctrl.valid <= 1'b0;
			ctrl.aluOp <= aluPass;
			ctrl.operandSel <= selConstants;
			ctrl.accControl <= noLoad;
			ctrl.memControl <= memNone;
		end else begin
			ctrl.valid <= popped;
			if (popped) begin
				ctrl.aluOp <= decAluOp;
				ctrl.operandSel <= decOperandSel;
				ctrl.accControl <= decAccControl;
				ctrl.memControl <= decMemControl;
			end
		end
	end

	// payload, the two views of the head word
	always_ff @(posedge clk) begin
		if (popped) begin
			ctrl.constant <= head.fmtImm.constant;
			ctrl.addr <= head.fmtAddr.addr;
		end
	end

endmodule

//--- logic/exCtrlIf.sv
interface exCtrlIf;

	// one decoded instruction, valid for a single execute cycle
	logic valid;
	cpuPkg::aluOpT aluOp;
	logic [1:0] operandSel;
	logic [2:0] accControl;
	logic [1:0] memControl;
	// immediate and memory address payload
	logic [7:0] constant;
	logic [9:0] addr;

	modport decoder (
		output valid, aluOp, operandSel, accControl, memControl, constant, addr
	);

	modport execute (
		input valid, aluOp, operandSel, accControl, memControl, constant, addr
	);

endinterface

//--- logic/cpuPkg.sv
package cpuPkg;

	// opcodes, six bits wide, NOP must stay at zero
	localparam logic [5:0] NOP   = 6'd0;
	localparam logic [5:0] LDA   = 6'd1;
	localparam logic [5:0] LDB   = 6'd2;
	localparam logic [5:0] LDCA  = 6'd3;
	localparam logic [5:0] LDCB  = 6'd4;
	localparam logic [5:0] STA   = 6'd5;
	localparam logic [5:0] STB   = 6'd6;
	localparam logic [5:0] ADDA  = 6'd7;
	localparam logic [5:0] ADDB  = 6'd8;
	localparam logic [5:0] ADDCA = 6'd9;
	localparam logic [5:0] ADDCB = 6'd10;
	localparam logic [5:0] SUBA  = 6'd11;
	localparam logic [5:0] SUBB  = 6'd12;
	localparam logic [5:0] SUBCA = 6'd13;
	localparam logic [5:0] SUBCB = 6'd14;
	localparam logic [5:0] ANDA  = 6'd15;
	localparam logic [5:0] ANDB  = 6'd16;
	localparam logic [5:0] ANDCA = 6'd17;
	localparam logic [5:0] ANDCB = 6'd18;
	localparam logic [5:0] ORA   = 6'd19;
	localparam logic [5:0] ORB   = 6'd20;
	localparam logic [5:0] ORCA  = 6'd21;
	localparam logic [5:0] ORCB  = 6'd22;
	localparam logic [5:0] ASLA  = 6'd23;
	localparam logic [5:0] ASRA  = 6'd24;

	// one instruction word, constant view and address view
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [1:0] spare;
			logic [7:0] constant;
		} fmtImm;
		struct packed {
			logic [5:0] opcode;
			logic [9:0] addr;
		} fmtAddr;
	} instrWord;

	typedef enum logic [2:0] {
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluShl,
		aluShr
	} aluOpT;

	// bit 0 picks A for operand 1, bit 1 picks B for operand 2
	localparam logic [1:0] selConstants   = 2'b00;
	localparam logic [1:0] selAcumAConstB = 2'b01;
	localparam logic [1:0] selConstAAcumB = 2'b10;
	localparam logic [1:0] selAcumAB      = 2'b11;

	// accumulator load control
	localparam logic [2:0] noLoad = 3'd0;
	localparam logic [2:0] loadA  = 3'd1;
	localparam logic [2:0] loadB  = 3'd2;

	// memory access control
	localparam logic [1:0] memNone  = 2'd0;
	localparam logic [1:0] memRead  = 2'd1;
	localparam logic [1:0] memWrite = 2'd2;

	// credit depths and derived widths
	localparam int INSTR_CREDITS = 2;
	localparam int STORE_CREDITS = 2;
	localparam int INSTR_PTR_W = $clog2(INSTR_CREDITS);
	localparam int INSTR_CNT_W = $clog2(INSTR_CREDITS + 1);
	localparam int STORE_CNT_W = $clog2(STORE_CREDITS + 1);
	localparam int MEM_DEPTH = 1024;

endpackage
